//--- ppu_defines.svh
/*
 * widths, game-window placement and memory depths
 * shared by the background layer
 */
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// vga raster coordinates
`define PPU_POS_BITS       10

// first game pixel on the 640x480 raster
`define PPU_GAME_X0        192
`define PPU_GAME_Y0        120

// game window size
`define PPU_WIN_W          256
`define PPU_WIN_H          240
`define PPU_SCROLL_BITS    9

`define PPU_RGB_BITS       12

// name/attribute words and pattern tiles
`define PPU_NAME_WORDS     512
`define PPU_NAME_WORD_BITS 32
`define PPU_TILE_COUNT     256
`define PPU_TILE_BITS      128

`endif

//--- ppuGeomPkg.sv
/*
 * raster position, pixel tag, scroll pointer and
 * name-RAM address types
 */
`default_nettype none

`include "ppu_defines.svh"

package ppuGeomPkg;

    typedef logic [`PPU_POS_BITS-1:0] coordT;

    // vga coordinates, 20 bits
    typedef struct packed {
        coordT x;
        coordT y;
    } vgaPos;

    // position in flight through the renderer
    typedef struct packed {
        logic  valid;
        vgaPos pos;
    } pixelTag;

    // 0..239 upper screen, 256..495 lower screen
    typedef logic [`PPU_SCROLL_BITS-1:0] scrollT;

    typedef logic [`PPU_SCROLL_BITS-1:0] nameAddr;

    // cpu write of the pending scroll pointer
    typedef struct packed {
        logic   strobe;
        scrollT value;
    } scrollWrite;

endpackage

`default_nettype wire

//--- ppuColorPkg.sv
/*
 * colour, palette and pattern-tile types plus the
 * cpu write structs and the rendered pixel
 */
`default_nettype none

`include "ppu_defines.svh"

package ppuColorPkg;

    typedef logic [`PPU_RGB_BITS-1:0]       rgbT;
    typedef logic [1:0]                     palChoice;
    typedef logic [`PPU_NAME_WORD_BITS-1:0] nameWordT;

    // one colour per 2-bit pixel code
    typedef struct packed {
        rgbT code3;
        rgbT code2;
        rgbT code1;
        rgbT code0;
    } paletteQuad;

    // low plane rows in 127..64, high plane rows in 63..0
    typedef logic [`PPU_TILE_BITS-1:0] tileT;

    typedef struct packed {
        logic                strobe;
        ppuGeomPkg::nameAddr addr;
        nameWordT            data;
    } nameWrite;

    typedef struct packed {
        logic       strobe;
        logic [7:0] idx;
        tileT       data;
    } tileWrite;

    typedef struct packed {
        logic       strobe;
        logic       bank;
        palChoice   pal;
        logic [1:0] code;
        rgbT        color;
    } paletteWrite;

    // rendered pixel, tagged with its raster position
    typedef struct packed {
        logic              valid;
        ppuGeomPkg::vgaPos pos;
        rgbT               rgb;
    } pixelOut;

endpackage

`default_nettype wire

//--- tableRam.sv
/*
 * register-array memory with one clocked write port and
 * an asynchronous read port, entry type set by parameter
 */
`timescale 1ns/10ps
`default_nettype none

module tableRam #(
    parameter type entryT = logic [31:0],
    parameter int  DEPTH  = 512
) (
    input  wire logic                     clk,
    input  wire logic                     wrEn,
    input  wire logic [$clog2(DEPTH)-1:0] wrAddr,
    input  wire entryT                    wrData,
    input  wire logic [$clog2(DEPTH)-1:0] rdAddr,
    output entryT                         rdData
);

    entryT mem [DEPTH];

    // cpu side
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // renderer side, combinational
    assign rdData = mem[rdAddr];

endmodule

`default_nettype wire

//--- bgPalette.sv
/*
 * background palette registers, 2 banks x 4 palettes x 4 colours,
 * giving the four colours of one palette in the selected bank
 */
`timescale 1ns/10ps
`default_nettype none

module bgPalette (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire ppuColorPkg::paletteWrite palWr,
    input  wire logic                     bankHigh,
    input  wire ppuColorPkg::palChoice    choice,
    output ppuColorPkg::paletteQuad       colors
);
    import ppuColorPkg::*;

    // [bank][palette][code]
    rgbT palMem [2][4][4];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int b = 0; b < 2; b++) begin
                for (int p = 0; p < 4; p++) begin
                    for (int c = 0; c < 4; c++) begin
                        palMem[b][p][c] <= '0;
                    end
                end
            end
        end else if (palWr.strobe) begin
            palMem[palWr.bank][palWr.pal][palWr.code] <= palWr.color;
        end
    end

    // bank follows the cpu level directly
    assign colors = {
        palMem[bankHigh][choice][3],
        palMem[bankHigh][choice][2],
        palMem[bankHigh][choice][1],
        palMem[bankHigh][choice][0]
    };

endmodule

`default_nettype wire

//--- scanCtrl.sv
/*
 * raster walk over the 256x240 game window, one pixel per clock,
 * with the vertical scroll pointer latched at frame start
 */
`timescale 1ns/10ps
`default_nettype none

`include "ppu_defines.svh"

module scanCtrl (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   run,
    input  wire ppuGeomPkg::scrollWrite scrollWr,
    output ppuGeomPkg::pixelTag         pos,
    output ppuGeomPkg::scrollT          scroll
);
    import ppuGeomPkg::*;

    logic [7:0] winX;
    logic [7:0] winY;
    scrollT     pending;
    logic       lastX;
    logic       lastY;
    logic       frameStart;

    assign lastX      = (winX == 8'(`PPU_WIN_W - 1));
    assign lastY      = (winY == 8'(`PPU_WIN_H - 1));
    assign frameStart = run && (winX == '0) && (winY == '0);

    // window counters, frozen while run is low
    always_ff @(posedge clk) begin
        if (!rstn) begin
            winX <= '0;
            winY <= '0;
        end else if (run) begin
            winX <= lastX ? '0 : winX + 8'd1;
            if (lastX) begin
                winY <= lastY ? '0 : winY + 8'd1;
            end
        end
    end

    // issued position, offset into vga space
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pos <= '0;
        end else begin
            pos.valid <= run;
            if (run) begin
                pos.pos.x <= coordT'(winX) + coordT'(`PPU_GAME_X0);
                pos.pos.y <= coordT'(winY) + coordT'(`PPU_GAME_Y0);
            end
        end
    end

    // cpu writes go to pending, active pointer only moves at frame start
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pending <= '0;
            scroll  <= '0;
        end else begin
            if (scrollWr.strobe) begin
                pending <= scrollWr.value;
            end
            if (frameStart) begin
                scroll <= pending;
            end
        end
    end

endmodule

`default_nettype wire

//--- bgTileFetch.sv
/*
 * three-stage background renderer: pixel position to name and
 * attribute lookup, tile byte and palette field, then colour
 */
`timescale 1ns/10ps
`default_nettype none

`include "ppu_defines.svh"

module bgTileFetch (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire ppuGeomPkg::pixelTag     pos,
    input  wire ppuGeomPkg::scrollT      scroll,
    output ppuGeomPkg::nameAddr          nameRdAddr,
    output ppuGeomPkg::nameAddr          attrRdAddr,
    input  wire ppuColorPkg::nameWordT   nameWord,
    input  wire ppuColorPkg::nameWordT   attrWord,
    output logic [7:0]                   tileIdx,
    input  wire ppuColorPkg::tileT       tileData,
    output ppuColorPkg::palChoice        palSel,
    input  wire ppuColorPkg::paletteQuad colors,
    output ppuColorPkg::pixelOut         pixOut
);
    import ppuGeomPkg::*;
    import ppuColorPkg::*;

    // input side address math
    coordT      gameX;
    coordT      gameY;
    scrollT     gy;
    logic       inScreen;
    logic [5:0] rowAdj;

    // stage 1
    pixelTag    s1Tag;
    nameAddr    s1Name;
    logic [7:0] s1X;
    logic [2:0] s1FineY;
    logic [7:0] tileByte;
    logic [7:0] attrByte;
    palChoice   attrField;

    // stage 2
    pixelTag    s2Tag;
    logic [7:0] s2Tile;
    logic [5:0] s2Bit;
    palChoice   s2Pal;
    logic [6:0] lowIdx;
    logic [6:0] highIdx;
    logic [1:0] code;
    rgbT        color;

    assign gameX = pos.pos.x - coordT'(`PPU_GAME_X0);
    assign gameY = pos.pos.y - coordT'(`PPU_GAME_Y0);
    assign gy    = gameY[8:0] + scroll;

    // gy still on the same screen as the scroll pointer
    assign inScreen = (gy[8] == scroll[8]) && (gy[7:0] < 8'(`PPU_WIN_H));
    // otherwise step over the two unused rows between screens
    assign rowAdj   = inScreen ? gy[8:3] : gy[8:3] + 6'd2;

    always_ff @(posedge clk) begin
        s1Tag   <= pos;
        s1Name  <= {rowAdj, gameX[7:5]};
        s1X     <= gameX[7:0];
        s1FineY <= gy[2:0];
        if (!rstn) begin
            s1Tag.valid <= 1'b0;
        end
    end

    assign nameRdAddr = s1Name;
    // attribute words sit at the top of each screen's name space
    assign attrRdAddr = {s1Name[8] ? 5'b11111 : 5'b01111, s1Name[7:5], s1X[7]};

    // byte 0 is the most significant
    always_comb begin
        case (s1X[4:3])
            2'b00:   tileByte = nameWord[31:24];
            2'b01:   tileByte = nameWord[23:16];
            2'b10:   tileByte = nameWord[15:8];
            default: tileByte = nameWord[7:0];
        endcase
    end

    always_comb begin
        case (s1X[6:5])
            2'b00:   attrByte = attrWord[31:24];
            2'b01:   attrByte = attrWord[23:16];
            2'b10:   attrByte = attrWord[15:8];
            default: attrByte = attrWord[7:0];
        endcase
    end

    // 16-pixel quadrant within the attribute byte
    always_comb begin
        case ({s1Name[4], s1X[4]})
            2'b00:   attrField = attrByte[1:0];
            2'b01:   attrField = attrByte[3:2];
            2'b10:   attrField = attrByte[5:4];
            default: attrField = attrByte[7:6];
        endcase
    end

    always_ff @(posedge clk) begin
        s2Tag  <= s1Tag;
        s2Tile <= tileByte;
        s2Bit  <= {s1FineY, s1X[2:0]};
        s2Pal  <= attrField;
        if (!rstn) begin
            s2Tag.valid <= 1'b0;
        end
    end

    assign tileIdx = s2Tile;
    assign palSel  = s2Pal;

    // row-major from the top of each plane
    assign lowIdx  = 7'd127 - {1'b0, s2Bit};
    assign highIdx = 7'd63 - {1'b0, s2Bit};
    assign code    = {tileData[lowIdx], tileData[highIdx]};

    always_comb begin
        case (code)
            2'b00:   color = colors.code0;
            2'b01:   color = colors.code1;
            2'b10:   color = colors.code2;
            default: color = colors.code3;
        endcase
    end

    // tag travels with the colour so layers can be merged later
    always_ff @(posedge clk) begin
        pixOut.valid <= s2Tag.valid;
        pixOut.pos   <= s2Tag.pos;
        pixOut.rgb   <= color;
        if (!rstn) begin
            pixOut.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- ppuBackground.sv
/*
 * background layer top: scan controller, tile renderer,
 * palette and the name, attribute and pattern memories
 */
`timescale 1ns/10ps
`default_nettype none

`include "ppu_defines.svh"

module ppuBackground (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire logic                     run,
    input  wire ppuGeomPkg::scrollWrite   scrollWr,
    input  wire ppuColorPkg::nameWrite    nameWr,
    input  wire ppuColorPkg::tileWrite    tileWr,
    input  wire ppuColorPkg::paletteWrite palWr,
    input  wire logic                     bankHigh,
    output ppuColorPkg::pixelOut          pixOut
);
    import ppuGeomPkg::*;
    import ppuColorPkg::*;

    pixelTag    scanPos;
    scrollT     scrollNow;
    nameAddr    nameRdAddr;
    nameAddr    attrRdAddr;
    nameWordT   nameWord;
    nameWordT   attrWord;
    logic [7:0] tileIdx;
    tileT       tileData;
    palChoice   palSel;
    paletteQuad palColors;

    scanCtrl uScan (
        .clk     (clk),
        .rstn    (rstn),
        .run     (run),
        .scrollWr(scrollWr),
        .pos     (scanPos),
        .scroll  (scrollNow)
    );

    bgTileFetch uFetch (
        .clk       (clk),
        .rstn      (rstn),
        .pos       (scanPos),
        .scroll    (scrollNow),
        .nameRdAddr(nameRdAddr),
        .attrRdAddr(attrRdAddr),
        .nameWord  (nameWord),
        .attrWord  (attrWord),
        .tileIdx   (tileIdx),
        .tileData  (tileData),
        .palSel    (palSel),
        .colors    (palColors),
        .pixOut    (pixOut)
    );

    bgPalette uPalette (
        .clk     (clk),
        .rstn    (rstn),
        .palWr   (palWr),
        .bankHigh(bankHigh),
        .choice  (palSel),
        .colors  (palColors)
    );

    // attribute copy takes the same writes, second read port
    tableRam #(.entryT(nameWordT), .DEPTH(`PPU_NAME_WORDS)) nameRam (
        .clk(clk), .wrEn(nameWr.strobe), .wrAddr(nameWr.addr),
        .wrData(nameWr.data), .rdAddr(nameRdAddr), .rdData(nameWord)
    );

    tableRam #(.entryT(nameWordT), .DEPTH(`PPU_NAME_WORDS)) attrRam (
        .clk(clk), .wrEn(nameWr.strobe), .wrAddr(nameWr.addr),
        .wrData(nameWr.data), .rdAddr(attrRdAddr), .rdData(attrWord)
    );

    tableRam #(.entryT(tileT), .DEPTH(`PPU_TILE_COUNT)) patRam (
        .clk(clk), .wrEn(tileWr.strobe), .wrAddr(tileWr.idx),
        .wrData(tileWr.data), .rdAddr(tileIdx), .rdData(tileData)
    );

endmodule

`default_nettype wire

//--- ppuBackground_tb.sv
/*
 * background layer testbench with memory setup through the cpu write structs,
 * a stimulus table checked against a reference model and a tag latency check
 */
`timescale 1ns/10ps
`default_nettype none

`include "ppu_defines.svh"

module ppuBackground_tb;
    import ppuGeomPkg::*;
    import ppuColorPkg::*;

    localparam int NUM_ROWS     = 5;
    localparam int FRAME_CYCLES = `PPU_WIN_W * `PPU_WIN_H;
    // each row waits up to one frame for its start and one more for its pixels
    localparam int CYCLE_LIMIT  = (2 * NUM_ROWS + 1) * FRAME_CYCLES + 4000;

    logic        clk = 1'b0;
    logic        rstn;
    logic        run;
    scrollWrite  scrollWr;
    nameWrite    nameWr;
    tileWrite    tileWr;
    paletteWrite palWr;
    logic        bankHigh;
    pixelOut     pixOut;

    // shadow copies of what the cpu wrote
    logic [31:0] nameShadow [`PPU_NAME_WORDS];
    tileT        tileShadow [16];
    rgbT         palShadow  [2][4][4];

    // stimulus table in window coordinates and raster order
    // a -1 ends a position list
    string rowName   [NUM_ROWS] = '{"tileRowScroll0", "attrQuadrants", "bankHigh",
                                    "scroll200Wrap", "scroll300Lower"};
    int    rowScroll [NUM_ROWS] = '{0, 0, 0, 200, 300};
    bit    rowBank   [NUM_ROWS] = '{0, 0, 1, 0, 1};
    int    rowX [NUM_ROWS][8] = '{
        '{0, 1, 2, 3, 4, 5, 6, 7},
        '{3, 20, 5, 22, -1, -1, -1, -1},
        '{0, 3, 20, 22, 255, -1, -1, -1},
        '{10, 10, 11, 100, 200, -1, -1, -1},
        '{7, 150, 40, 41, 250, -1, -1, -1}
    };
    int    rowY [NUM_ROWS][8] = '{
        '{8, 8, 8, 8, 8, 8, 8, 8},
        '{35, 37, 50, 52, -1, -1, -1, -1},
        '{8, 8, 37, 52, 239, -1, -1, -1},
        '{30, 39, 40, 100, 239, -1, -1, -1},
        '{0, 100, 195, 196, 239, -1, -1, -1}
    };

    integer  seed = 997;
    int      errors = 0;
    int      testsRun = 0;
    int      testsFailed = 0;
    int      cycles = 0;
    bit      runSeen = 1'b0;
    pixelTag issued [$];

    ppuBackground DUT (
        .clk(clk), .rstn(rstn), .run(run), .scrollWr(scrollWr), .nameWr(nameWr),
        .tileWr(tileWr), .palWr(palWr), .bankHigh(bankHigh), .pixOut(pixOut)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: an expected pixel never came out within %0d cycles",
                     CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    function automatic bit inWindow(input vgaPos p);
        return p.x >= `PPU_GAME_X0 && p.x < `PPU_GAME_X0 + `PPU_WIN_W
            && p.y >= `PPU_GAME_Y0 && p.y < `PPU_GAME_Y0 + `PPU_WIN_H;
    endfunction

    // raster order step over the game window
    function automatic void stepRaster(inout int x, inout int y);
        if (x == `PPU_WIN_W - 1) begin
            x = 0;
            y = (y == `PPU_WIN_H - 1) ? 0 : y + 1;
        end else begin
            x++;
        end
    endfunction

    // output idle before run and every tag inside the game window
    always @(negedge clk) begin
        if (rstn && !runSeen) begin
            checkValue("idleBeforeRun", 0, pixOut.valid);
        end
        if (pixOut.valid) begin
            checkValue("tagInWindow", 1, inWindow(pixOut.pos));
        end
    end

    // reference colour from the shadow arrays
    function automatic rgbT modelColor(input int wx, input int wy, input int scroll,
                                       input bit bank);
        int         gy;
        int         row;
        int         nameA;
        int         attrA;
        int         field;
        int         bitPos;
        bit         inRange;
        logic [7:0] tile;
        logic [7:0] attr;
        logic [1:0] pal;
        logic [1:0] code;
        tileT       pat;
        gy      = (wy + scroll) % 512;
        inRange = (scroll < 256) ? (gy < 240) : (gy >= 256 && gy < 496);
        row     = gy / 8;
        // two unused rows between the screens
        if (!inRange) begin
            row = (row + 2) % 64;
        end
        nameA  = row * 8 + wx / 32;
        tile   = nameShadow[nameA][31 - 8 * ((wx / 8) % 4) -: 8];
        attrA  = (nameA >= 256 ? 496 : 240) + ((nameA / 32) % 8) * 2 + wx / 128;
        attr   = nameShadow[attrA][31 - 8 * ((wx / 32) % 4) -: 8];
        field  = ((nameA / 16) % 2) * 2 + (wx / 16) % 2;
        pal    = attr[2 * field +: 2];
        bitPos = (gy % 8) * 8 + wx % 8;
        pat    = tileShadow[tile[3:0]];
        code   = {pat[127 - bitPos], pat[63 - bitPos]};
        return palShadow[bank][pal][code];
    endfunction

    task automatic loadMemories();
        logic [31:0] word;
        tileT        pat;
        for (int a = 0; a < `PPU_NAME_WORDS; a++) begin
            word = $random(seed);
            // name words use tiles 0..15 and the top 16 words of each screen hold attributes
            if (a % 256 < 240) begin
                word = word & 32'h0F0F0F0F;
            end
            nameShadow[a] = word;
            @(negedge clk);
            nameWr = '{1'b1, nameAddr'(a), word};
        end
        for (int t = 0; t < 16; t++) begin
            pat = {$random(seed), $random(seed), $random(seed), $random(seed)};
            // top row opens with codes 0, 1, 2, 3
            pat[127:124]  = 4'b0011;
            pat[63:60]    = 4'b0101;
            tileShadow[t] = pat;
            @(negedge clk);
            nameWr.strobe = 1'b0;
            tileWr = '{1'b1, 8'(t), pat};
        end
        for (int b = 0; b < 2; b++) begin
            for (int p = 0; p < 4; p++) begin
                for (int c = 0; c < 4; c++) begin
                    palShadow[b][p][c] = 12'($random(seed));
                    @(negedge clk);
                    tileWr.strobe = 1'b0;
                    palWr = '{1'b1, 1'(b), palChoice'(p), 2'(c), palShadow[b][p][c]};
                end
            end
        end
        @(negedge clk);
        palWr.strobe = 1'b0;
    endtask

    task automatic findPixel(input int wx, input int wy);
        while (!(pixOut.valid && pixOut.pos.x == coordT'(wx + `PPU_GAME_X0)
                 && pixOut.pos.y == coordT'(wy + `PPU_GAME_Y0))) begin
            @(negedge clk);
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testsRun++;
        if (errors == startErrors) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d mismatches", name, errors - startErrors);
        end
    endtask

    initial begin
        int      startErrors;
        int      wx;
        int      wy;
        int      scanX;
        int      scanY;
        pixelTag issuedTag;
        pixelTag expTag;
        rstn     = 1'b0;
        run      = 1'b0;
        bankHigh = 1'b0;
        scrollWr = '0;
        nameWr   = '0;
        tileWr   = '0;
        palWr    = '0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        startErrors = errors;
        loadMemories();
        reportTest("idleAfterReset", startErrors);
        run     = 1'b1;
        runSeen = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            startErrors = errors;
            @(negedge clk);
            scrollWr = '{1'b1, scrollT'(rowScroll[r])};
            bankHigh = rowBank[r];
            @(negedge clk);
            scrollWr.strobe = 1'b0;
            // a frame starting after the write shows up 3 cycles later
            repeat (4) @(negedge clk);
            findPixel(0, 0);
            for (int i = 0; i < 8 && rowX[r][i] >= 0; i++) begin
                findPixel(rowX[r][i], rowY[r][i]);
                checkValue(rowName[r],
                           modelColor(rowX[r][i], rowY[r][i], rowScroll[r], rowBank[r]),
                           pixOut.rgb);
            end
            reportTest(rowName[r], startErrors);
        end

        // consecutive tags against a model of the raster walk with run low for four cycles
        startErrors = errors;
        issued.delete();
        // pixOut shows the last table position and the next three are already issued
        scanX = rowX[NUM_ROWS - 1][4];
        scanY = rowY[NUM_ROWS - 1][4];
        issuedTag.valid = 1'b1;
        for (int k = 0; k < 3; k++) begin
            stepRaster(scanX, scanY);
            issuedTag.pos.x = coordT'(scanX + `PPU_GAME_X0);
            issuedTag.pos.y = coordT'(scanY + `PPU_GAME_Y0);
            issued.push_back(issuedTag);
        end
        stepRaster(scanX, scanY);
        for (int c = 0; c < 40; c++) begin
            @(negedge clk);
            // the edge just passed issued a new position only while run was high
            issuedTag.valid = run;
            if (run) begin
                issuedTag.pos.x = coordT'(scanX + `PPU_GAME_X0);
                issuedTag.pos.y = coordT'(scanY + `PPU_GAME_Y0);
                stepRaster(scanX, scanY);
            end
            issued.push_back(issuedTag);
            expTag = issued.pop_front();
            checkValue("pipelineValid", expTag.valid, pixOut.valid);
            checkValue("pipelinePos", expTag.pos, pixOut.pos);
            if (expTag.valid) begin
                wx = int'(expTag.pos.x) - `PPU_GAME_X0;
                wy = int'(expTag.pos.y) - `PPU_GAME_Y0;
                checkValue("pipelineColor",
                           modelColor(wx, wy, rowScroll[NUM_ROWS - 1],
                                      rowBank[NUM_ROWS - 1]),
                           pixOut.rgb);
            end
            run = (c < 20 || c > 23);
        end
        reportTest("pipelineTags", startErrors);

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
ppuGeomPkg.sv
ppuColorPkg.sv
tableRam.sv
bgPalette.sv
scanCtrl.sv
bgTileFetch.sv
ppuBackground.sv
ppuBackground_tb.sv

//--- Makefile
# Verilator build and run of the background layer testbench

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0 -Mdir obj_dir
TOP      = ppuBackground_tb
FILELIST = vlog.f
PASS     = Test completed successfully

SOURCES  = $(filter-out +%,$(shell cat $(FILELIST))) ppu_defines.svh
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf obj_dir
